// File: common/board_pkg.sv
// Board pin map and register constants

`default_nettype none

package board_pkg;

	// Pad bus width, one bit per board pin
	localparam int N_PADS = 8;

	// Pin indices into the pad vectors
	localparam int PIN_UART_TX    = 0;
	localparam int PIN_UART_RX    = 1;
	localparam int PIN_FLASH_MISO = 2;
	localparam int PIN_FLASH_MOSI = 3;
	localparam int PIN_FLASH_CS   = 4;
	localparam int PIN_FLASH_SCLK = 5;
	localparam int PIN_LED        = 6;
	// Bit 7 has no pin assigned yet

	// Register bus address width
	localparam int W_ADDR = 3;

	// GPIO register map
	typedef enum logic [W_ADDR-1:0] {
		// Pad output values, read/write
		REG_OUT     = 3'd0,
		// Output enables, read/write
		REG_OE      = 3'd1,
		// Synchronized pad inputs, read only
		REG_IN      = 3'd2,
		// OR ones into REG_OUT, reads as zero
		REG_OUT_SET = 3'd3,
		// Clear ones in REG_OUT, reads as zero
		REG_OUT_CLR = 3'd4
	} reg_addr_t;

	// Cycles the core stays in reset once lock and external reset are good
	localparam int RESET_HOLD_CYCLES = 8;

	// Counter width needed to hold RESET_HOLD_CYCLES
	localparam int W_RESET_CNT = $clog2(RESET_HOLD_CYCLES + 1);

	// Blink half period in clk_sys cycles
	// Scaled down from a 1 Hz blink so simulation stays short
	localparam int BLINK_HALF_CYCLES = 50;

	// Counter width for one blink half period
	localparam int W_BLINK_CNT = $clog2(BLINK_HALF_CYCLES);

endpackage

`default_nettype wire

// File: hdl/fpga_reset.sv
// Core reset generator

`default_nettype none

module fpga_reset (
	input  logic clk_sys,
	input  logic rst,
	input  logic pll_locked,
	output logic rst_core
);

	// Any reason to hold the core in reset right now
	logic force_rst;

	// Remaining hold cycles before release
	logic [board_pkg::W_RESET_CNT-1:0] hold_cnt;

	assign force_rst = rst || !pll_locked;

	// Reload on any reset cause, then count down to zero
	always_ff @(posedge clk_sys) begin
		if (force_rst) begin
			hold_cnt <= board_pkg::W_RESET_CNT'(board_pkg::RESET_HOLD_CYCLES);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// Registered output so the core never sees a glitch
	// Release lands on the same edge that takes the count to zero
	always_ff @(posedge clk_sys) begin
		if (force_rst) begin
			rst_core <= 1'b1;
		end else begin
			rst_core <= hold_cnt > board_pkg::W_RESET_CNT'(1);
		end
	end

endmodule

`default_nettype wire

// File: gpio/gpio_regs.sv
// GPIO register block

`default_nettype none

module gpio_regs (
	input  logic                           clk_sys,
	input  logic                           rst_core,

	input  board_pkg::reg_addr_t           bus_addr,
	input  logic                           bus_wen,
	input  logic                           bus_ren,
	input  logic [board_pkg::N_PADS-1:0]   bus_wdata,
	output logic [board_pkg::N_PADS-1:0]   bus_rdata,

	output logic [board_pkg::N_PADS-1:0]   pad_out,
	output logic [board_pkg::N_PADS-1:0]   pad_oe,
	input  logic [board_pkg::N_PADS-1:0]   pad_in
);

	// Output and enable registers
	logic [board_pkg::N_PADS-1:0] out_q;
	logic [board_pkg::N_PADS-1:0] oe_q;

	// Two-stage input synchronizer
	logic [board_pkg::N_PADS-1:0] in_meta;
	logic [board_pkg::N_PADS-1:0] in_sync;

	// Next value of the output register
	logic [board_pkg::N_PADS-1:0] out_next;

	// Write decode for the output register, including set and clear forms
	always_comb begin
		out_next = out_q;
		if (bus_wen) begin
			case (bus_addr)
				board_pkg::REG_OUT:     out_next = bus_wdata;
				board_pkg::REG_OUT_SET: out_next = out_q | bus_wdata;
				board_pkg::REG_OUT_CLR: out_next = out_q & ~bus_wdata;
				default:                out_next = out_q;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst_core) begin
			out_q <= '0;
		end else begin
			out_q <= out_next;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst_core) begin
			oe_q <= '0;
		end else if (bus_wen && bus_addr == board_pkg::REG_OE) begin
			oe_q <= bus_wdata;
		end
	end

	// Pads are asynchronous to clk_sys
	always_ff @(posedge clk_sys) begin
		in_meta <= pad_in;
		in_sync <= in_meta;
	end

	// Read data is registered and held until the next read
	// A read in the same cycle as a write sees the old value
	always_ff @(posedge clk_sys) begin
		if (rst_core) begin
			bus_rdata <= '0;
		end else if (bus_ren) begin
			case (bus_addr)
				board_pkg::REG_OUT: bus_rdata <= out_q;
				board_pkg::REG_OE:  bus_rdata <= oe_q;
				board_pkg::REG_IN:  bus_rdata <= in_sync;
				// Set/clear and unmapped addresses read as zero
				default:            bus_rdata <= '0;
			endcase
		end
	end

	assign pad_out = out_q;
	assign pad_oe  = oe_q;

endmodule

`default_nettype wire

// File: hdl/blinky.sv
// Heartbeat blinker

`default_nettype none

module blinky (
	input  logic clk_sys,
	input  logic rst_core,
	output logic blink
);

	// Cycle count within the current half period
	logic [board_pkg::W_BLINK_CNT-1:0] half_cnt;

	// Last cycle of a half period
	logic half_wrap;

	assign half_wrap = half_cnt ==
		board_pkg::W_BLINK_CNT'(board_pkg::BLINK_HALF_CYCLES - 1);

	always_ff @(posedge clk_sys) begin
		if (rst_core) begin
			half_cnt <= '0;
		end else if (half_wrap) begin
			half_cnt <= '0;
		end else begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	// Flip once per half period, starts dark out of reset
	always_ff @(posedge clk_sys) begin
		if (rst_core) begin
			blink <= 1'b0;
		end else if (half_wrap) begin
			blink <= !blink;
		end
	end

endmodule

`default_nettype wire

// File: hdl/board_top.sv
// Board I/O subsystem top level

`default_nettype none

module board_top (
	input  logic                           clk_sys,
	input  logic                           rst,
	input  logic                           pll_locked,

	// Register bus from the host side
	input  logic [board_pkg::W_ADDR-1:0]   bus_addr,
	input  logic                           bus_wen,
	input  logic                           bus_ren,
	input  logic [board_pkg::N_PADS-1:0]   bus_wdata,
	output logic [board_pkg::N_PADS-1:0]   bus_rdata,

	// Pad side, tristate cells live outside this level
	output logic [board_pkg::N_PADS-1:0]   pad_out,
	output logic [board_pkg::N_PADS-1:0]   pad_oe,
	input  logic [board_pkg::N_PADS-1:0]   pad_in,

	output logic [7:0]                     led
);

	// Core reset after lock and hold time
	logic rst_core;

	// Heartbeat from the blinker
	logic blink;

	fpga_reset u_reset (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.pll_locked (pll_locked),
		.rst_core   (rst_core)
	);

	gpio_regs u_gpio (
		.clk_sys   (clk_sys),
		.rst_core  (rst_core),
		.bus_addr  (board_pkg::reg_addr_t'(bus_addr)),
		.bus_wen   (bus_wen),
		.bus_ren   (bus_ren),
		.bus_wdata (bus_wdata),
		.bus_rdata (bus_rdata),
		.pad_out   (pad_out),
		.pad_oe    (pad_oe),
		.pad_in    (pad_in)
	);

	blinky u_blinky (
		.clk_sys  (clk_sys),
		.rst_core (rst_core),
		.blink    (blink)
	);

	// Status LEDs
	// Bit 7 lights while TX idles low, bit 6 shows RX straight from the pin
	// Bit 0 only lights when the LED pin is actually driven
	assign led = {
		!pad_out[board_pkg::PIN_UART_TX],
		!pad_in[board_pkg::PIN_UART_RX],
		4'h0,
		blink,
		pad_out[board_pkg::PIN_LED] && pad_oe[board_pkg::PIN_LED]
	};

endmodule

`default_nettype wire

// File: bench/tb_board_top.sv
// Board I/O subsystem testbench

`default_nettype none

module tb_board_top;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_HALF = 50;
	localparam int DRIVE_DLY = 10;
	localparam int RESET_CYCLES = 16;
	localparam int N_WR = 6;
	localparam int N_SC = 8;
	localparam int N_IN = 4;
	localparam int N_BLINK = 3;
	localparam int N_ZERO = 5;

	// Cycle budget of each test in order, plus margin
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 + board_pkg::RESET_HOLD_CYCLES + 1
		+ 4 * N_WR + 2 * N_SC + 3 + 2 * N_ZERO + 3 * N_IN + 8
		+ (N_BLINK + 2) * board_pkg::BLINK_HALF_CYCLES + 100;

	logic                           clk_sys;
	logic                           rst;
	logic                           pll_locked;
	logic [board_pkg::W_ADDR-1:0]   bus_addr;
	logic                           bus_wen;
	logic                           bus_ren;
	logic [board_pkg::N_PADS-1:0]   bus_wdata;
	logic [board_pkg::N_PADS-1:0]   bus_rdata;
	logic [board_pkg::N_PADS-1:0]   pad_out;
	logic [board_pkg::N_PADS-1:0]   pad_oe;
	logic [board_pkg::N_PADS-1:0]   pad_in;
	logic [7:0]                     led;

	logic [31:0] lfsr_state;
	int          n_checks;
	int          n_errors;

	board_top u_dut (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.pll_locked (pll_locked),
		.bus_addr   (bus_addr),
		.bus_wen    (bus_wen),
		.bus_ren    (bus_ren),
		.bus_wdata  (bus_wdata),
		.bus_rdata  (bus_rdata),
		.pad_out    (pad_out),
		.pad_oe     (pad_oe),
		.pad_in     (pad_in),
		.led        (led)
	);

	initial begin
		clk_sys = 1'b0;
		forever #CLK_HALF clk_sys = !clk_sys;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

	// Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic lsb;
		lsb = s[0];
		s = s >> 1;
		if (lsb) begin
			s = s ^ 32'h8020_0003;
		end
		return s;
	endfunction

	function automatic logic [board_pkg::N_PADS-1:0] rand_pads();
		logic [board_pkg::N_PADS-1:0] v;
		v = '0;
		for (int i = 0; i < board_pkg::N_PADS; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v[i] = lfsr_state[0];
		end
		return v;
	endfunction

	function automatic logic [board_pkg::N_PADS-1:0] pin_mask(input int pin);
		logic [board_pkg::N_PADS-1:0] m;
		m = '0;
		m[pin] = 1'b1;
		return m;
	endfunction

	task automatic check_bits(input string name, input logic [board_pkg::N_PADS-1:0] got,
		input logic [board_pkg::N_PADS-1:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAILED at %0d ns: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		n_checks++;
		if (got != exp) begin
			n_errors++;
			$display("FAILED at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	// Inputs change a short delay after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DLY;
	endtask

	task automatic write_reg(input logic [board_pkg::W_ADDR-1:0] addr,
		input logic [board_pkg::N_PADS-1:0] data);
		bus_addr  = addr;
		bus_wdata = data;
		bus_wen   = 1'b1;
		next_cycle();
		bus_wen   = 1'b0;
	endtask

	// Read data is valid the cycle after the strobe
	task automatic read_reg(input logic [board_pkg::W_ADDR-1:0] addr,
		output logic [board_pkg::N_PADS-1:0] data);
		bus_addr = addr;
		bus_ren  = 1'b1;
		next_cycle();
		bus_ren  = 1'b0;
		data     = bus_rdata;
	endtask

	task automatic reset_release();
		logic [board_pkg::N_PADS-1:0] early;
		logic [board_pkg::N_PADS-1:0] late;
		early = rand_pads() | pin_mask(0);
		late  = rand_pads() | pin_mask(board_pkg::N_PADS - 1);
		repeat (RESET_CYCLES) next_cycle();
		rst = 1'b0;
		repeat (4) begin
			next_cycle();
			check_bit("rst_core", u_dut.rst_core, 1'b1);
		end
		check_bits("pad_out", pad_out, '0);
		check_bits("pad_oe", pad_oe, '0);
		check_bits("bus_rdata", bus_rdata, '0);
		check_bits("led", led, 8'h80);
		pll_locked = 1'b1;
		for (int i = 1; i <= board_pkg::RESET_HOLD_CYCLES; i++) begin
			next_cycle();
			check_bit("rst_core", u_dut.rst_core, i < board_pkg::RESET_HOLD_CYCLES);
			// Last write that still lands inside the hold window
			if (i == board_pkg::RESET_HOLD_CYCLES - 1) begin
				bus_addr  = board_pkg::REG_OE;
				bus_wdata = early;
				bus_wen   = 1'b1;
			end
		end
		check_bits("pad_oe", pad_oe, '0);
		write_reg(board_pkg::REG_OE, late);
		check_bits("pad_oe", pad_oe, late);
	endtask

	task automatic write_readback();
		logic [board_pkg::N_PADS-1:0] v;
		logic [board_pkg::N_PADS-1:0] w;
		logic [board_pkg::N_PADS-1:0] data;
		for (int n = 0; n < N_WR; n++) begin
			v = rand_pads();
			w = rand_pads();
			write_reg(board_pkg::REG_OUT, v);
			check_bits("pad_out", pad_out, v);
			write_reg(board_pkg::REG_OE, w);
			check_bits("pad_oe", pad_oe, w);
			check_bits("pad_out", pad_out, v);
			read_reg(board_pkg::REG_OUT, data);
			check_bits("bus_rdata", data, v);
			read_reg(board_pkg::REG_OE, data);
			check_bits("bus_rdata", data, w);
		end
	endtask

	task automatic set_clear_masks();
		logic [board_pkg::N_PADS-1:0] model;
		logic [board_pkg::N_PADS-1:0] mask;
		logic [board_pkg::N_PADS-1:0] data;
		logic [board_pkg::W_ADDR-1:0] addr;
		model = rand_pads();
		write_reg(board_pkg::REG_OUT, model);
		for (int n = 0; n < N_SC; n++) begin
			mask = rand_pads();
			write_reg(board_pkg::REG_OUT_SET, mask);
			model = model | mask;
			check_bits("pad_out", pad_out, model);
			mask = rand_pads();
			write_reg(board_pkg::REG_OUT_CLR, mask);
			model = model & ~mask;
			check_bits("pad_out", pad_out, model);
		end
		read_reg(board_pkg::REG_OUT, data);
		check_bits("bus_rdata", data, model);
		// Load nonzero read data first so a zero read is visible
		write_reg(board_pkg::REG_OE, '1);
		for (int a = 3; a < 3 + N_ZERO; a++) begin
			addr = a[board_pkg::W_ADDR-1:0];
			read_reg(board_pkg::REG_OE, data);
			check_bits("bus_rdata", data, '1);
			read_reg(addr, data);
			check_bits("bus_rdata", data, '0);
		end
	endtask

	task automatic input_sampling();
		logic [board_pkg::N_PADS-1:0] pat;
		logic [board_pkg::N_PADS-1:0] data;
		for (int n = 0; n < N_IN; n++) begin
			pat = rand_pads();
			pad_in = pat;
			// Two synchronizer stages, then the read cycle
			next_cycle();
			next_cycle();
			read_reg(board_pkg::REG_IN, data);
			check_bits("bus_rdata", data, pat);
		end
	endtask

	task automatic led_mapping();
		pad_in = pin_mask(board_pkg::PIN_UART_RX);
		write_reg(board_pkg::REG_OUT, '0);
		write_reg(board_pkg::REG_OE, pin_mask(board_pkg::PIN_LED));
		check_bit("led[0]", led[0], 1'b0);
		write_reg(board_pkg::REG_OUT_SET, pin_mask(board_pkg::PIN_LED));
		check_bit("led[0]", led[0], 1'b1);
		write_reg(board_pkg::REG_OE, '0);
		check_bit("led[0]", led[0], 1'b0);
		write_reg(board_pkg::REG_OE, pin_mask(board_pkg::PIN_LED));
		check_bit("led[0]", led[0], 1'b1);
		write_reg(board_pkg::REG_OUT_CLR, pin_mask(board_pkg::PIN_LED));
		check_bit("led[0]", led[0], 1'b0);
		check_bit("led[7]", led[7], 1'b1);
		write_reg(board_pkg::REG_OUT_SET, pin_mask(board_pkg::PIN_UART_TX));
		check_bit("led[7]", led[7], 1'b0);
		write_reg(board_pkg::REG_OUT_CLR, pin_mask(board_pkg::PIN_UART_TX));
		check_bit("led[7]", led[7], 1'b1);
		check_bit("led[6]", led[6], 1'b0);
		// RX bit is combinational from the raw pin
		pad_in[board_pkg::PIN_UART_RX] = 1'b0;
		#1;
		check_bit("led[6]", led[6], 1'b1);
		pad_in[board_pkg::PIN_UART_RX] = 1'b1;
		#1;
		check_bit("led[6]", led[6], 1'b0);
		check_bits("led[5:2]", led & 8'h3c, '0);
	endtask

	task automatic heartbeat_period();
		logic prev;
		int   cycles;
		int   toggles;
		prev    = led[1];
		cycles  = 0;
		toggles = 0;
		while (toggles <= N_BLINK) begin
			next_cycle();
			cycles++;
			if (led[1] !== prev) begin
				// First toggle only aligns the count
				if (toggles > 0) begin
					check_count("blink half period", cycles, board_pkg::BLINK_HALF_CYCLES);
				end
				prev = led[1];
				cycles = 0;
				toggles++;
			end else if (cycles > 2 * board_pkg::BLINK_HALF_CYCLES) begin
				n_errors++;
				$display("Heartbeat on led[1] stopped toggling at %0d ns", $time);
				break;
			end
		end
	endtask

	initial begin
		rst        = 1'b1;
		pll_locked = 1'b0;
		bus_addr   = '0;
		bus_wen    = 1'b0;
		bus_ren    = 1'b0;
		bus_wdata  = '0;
		pad_in     = pin_mask(board_pkg::PIN_UART_RX);
		lfsr_state = 32'd69226;
		n_checks   = 0;
		n_errors   = 0;
		reset_release();
		write_readback();
		set_clear_masks();
		input_sampling();
		led_mapping();
		heartbeat_period();
		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
common/board_pkg.sv
hdl/fpga_reset.sv
gpio/gpio_regs.sv
hdl/blinky.sv
hdl/board_top.sv
bench/tb_board_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the board I/O testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps \
	--top-module tb_board_top -f all.f -o tb_board_top &&
out=$(./obj_dir/tb_board_top) &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx 'sim passed' &&
exit 0 ||
exit 1
